//--- flist.f
+incdir+.
lc3b_types.sv
fetch_unit.sv
register_file.sv
decode_stage.sv
forwarding_controller.sv
execute_stage.sv
cpu.sv
cpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module cpu_tb -o cpu_tb_sim

out="$(./obj_dir/cpu_tb_sim 2>&1 || true)"
echo "$out"
if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

//--- cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_config.svh"

module cpu_tb;

    import lc3b_types::*;

    localparam int       NUM_INSTR      = 14;
    localparam int       TIMEOUT_CYCLES = NUM_INSTR * 8 + 50;
    localparam lc3b_word NOP_WORD       = 16'h0000;    // br with no condition bits.

    typedef struct packed {
        lc3b_word instr;
        logic     writes;
        lc3b_reg  dest;
        lc3b_word value;
    } prog_entry;

    logic     clk        = 1'b0;
    logic     rst_n;
    logic     imem_read;
    lc3b_word imem_addr;
    lc3b_word imem_rdata = NOP_WORD;
    logic     imem_resp  = 1'b0;
    logic     wb_valid;
    lc3b_reg  wb_dest;
    lc3b_word wb_data;

    prog_entry prog_table [NUM_INSTR];
    string     prog_name [NUM_INSTR];
    int        prog_count  = 0;
    int        seed        = 23;
    int        cycle_count = 0;
    int        wait_left   = 0;
    int        fetch_idx;
    logic      req_open    = 1'b0;
    lc3b_word  next_addr   = `LC3B_RESET_PC;
    int        resp_cycles [$];                        // cycles in which wb_valid is due.

    cpu UUT (
        .clk(clk), .rst_n(rst_n),
        .imem_read(imem_read), .imem_addr(imem_addr),
        .imem_rdata(imem_rdata), .imem_resp(imem_resp),
        .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the program did not retire within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input lc3b_reg expected,
                             input lc3b_reg actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input lc3b_word expected,
                              input lc3b_word actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_cycle(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAILED %s: expected cycle %0d, actual cycle %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic add_entry(input string name, input lc3b_word instr);
        prog_table[prog_count].instr = instr;
        prog_name[prog_count]        = name;
        prog_count++;
    endtask

    // runs the program over its own register file and fills in the expected writebacks.
    task automatic run_reference_model();
        lc3b_word regs [8];
        lc3b_word ins;
        lc3b_word opnd_b;
        lc3b_word result;
        logic     writes;
        foreach (regs[r]) regs[r] = '0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            ins    = prog_table[i].instr;
            opnd_b = ins[5] ? {{11{ins[4]}}, ins[4:0]} : regs[ins[2:0]];
            writes = 1'b1;
            case (lc3b_opcode'(ins[15:12]))
                op_add:  result = regs[ins[8:6]] + opnd_b;
                op_and:  result = regs[ins[8:6]] & opnd_b;
                op_not:  result = ~regs[ins[8:6]];
                default: begin
                    result = '0;
                    writes = 1'b0;
                end
            endcase
            prog_table[i].writes = writes;
            prog_table[i].dest   = ins[11:9];
            prog_table[i].value  = result;
            if (writes) begin
                regs[ins[11:9]] = result;
            end
        end
    endtask

    task automatic wait_for_writeback(input string name);
        int expected_cycle;
        do begin
            @(negedge clk);
        end while (!wb_valid);
        if (resp_cycles.size() == 0) begin
            $display("a writeback for %s came before its instruction was fetched", name);
            abort_run();
        end else begin
            expected_cycle = resp_cycles.pop_front();
            check_cycle({name, " retire"}, expected_cycle, cycle_count);
        end
    endtask

    // instruction memory that answers each request after 0 to 3 wait cycles.
    always @(negedge clk) begin
        imem_resp <= 1'b0;
        if (rst_n && imem_read) begin
            if (!req_open) begin
                wait_left = $unsigned($random(seed)) % 4;
                req_open  = 1'b1;
            end
            if (wait_left == 0) begin
                check_word("fetch address", next_addr, imem_addr);
                fetch_idx = int'(imem_addr[15:1]);
                if (fetch_idx < NUM_INSTR) begin
                    imem_rdata <= prog_table[fetch_idx].instr;
                    if (prog_table[fetch_idx].writes) begin
                        resp_cycles.push_back(cycle_count + 3);
                    end
                end else begin
                    imem_rdata <= NOP_WORD;
                end
                imem_resp <= 1'b1;
                req_open  = 1'b0;
                next_addr = next_addr + lc3b_word'(2);
            end else begin
                wait_left--;
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        add_entry("add r1 r0 #5", 16'h1225);       // r1 = 0005.
        add_entry("add r2 r1 #-3", 16'h147D);      // r2 = 0002.
        add_entry("and r3 r1 #-2", 16'h567E);      // r3 = 0004.
        add_entry("add r4 r1 r2", 16'h1842);       // r4 = 0007.
        add_entry("and r5 r4 r1", 16'h5B01);
        add_entry("not r6 r5", 16'h9D7F);          // r6 = fffa.
        add_entry("br never", 16'h0000);
        add_entry("add r7 r6 r4", 16'h1F84);       // wraps to 0001.
        add_entry("ldr r7", 16'h6E00);             // must not touch r7.
        add_entry("add r7 r7 r7", 16'h1FC7);
        add_entry("not r0 r7", 16'h91FF);
        add_entry("and r1 r0 r6", 16'h5206);
        add_entry("add r2 r1 #-16", 16'h1470);
        add_entry("add r3 r3 #15", 16'h16EF);      // r3 = 0013.
        run_reference_model();

        repeat (8) begin
            @(negedge clk);
            check_bit("imem_read in reset", 1'b0, imem_read);
            check_bit("wb_valid in reset", 1'b0, wb_valid);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("imem_read one cycle after reset", 1'b1, imem_read);

        for (int i = 0; i < NUM_INSTR; i++) begin
            if (prog_table[i].writes) begin
                wait_for_writeback(prog_name[i]);
                check_reg({prog_name[i], " dest"}, prog_table[i].dest, wb_dest);
                check_word({prog_name[i], " data"}, prog_table[i].value, wb_data);
            end
        end

        // only no-ops are fetched past the end of the table.
        repeat (10) begin
            @(negedge clk);
            check_bit("wb_valid after program end", 1'b0, wb_valid);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule : cpu_tb

`default_nettype wire

//--- cpu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu (
    input  logic                 clk,
    input  logic                 rst_n,

    // instruction port.
    output logic                 imem_read,
    output lc3b_types::lc3b_word imem_addr,
    input  lc3b_types::lc3b_word imem_rdata,
    input  logic                 imem_resp,

    // writeback port.
    output logic                 wb_valid,
    output lc3b_types::lc3b_reg  wb_dest,
    output lc3b_types::lc3b_word wb_data
);

    import lc3b_types::*;

    lc3b_word    fetch_ir;
    logic        fetch_valid;
    lc3b_reg     rd_a;
    lc3b_reg     rd_b;
    lc3b_word    data_a;
    lc3b_word    data_b;
    lc3b_ex_in   ex_in;
    lc3b_fwd_sel fwd_a;
    lc3b_fwd_sel fwd_b;
    lc3b_wb_out  wb;

    fetch_unit _fetch_unit (
        .clk, .rst_n,
        .imem_read, .imem_addr, .imem_rdata, .imem_resp,
        .fetch_ir, .fetch_valid
    );

    decode_stage _decode_stage (
        .clk, .rst_n,
        .fetch_ir, .fetch_valid,
        .rd_a, .rd_b, .data_a, .data_b,
        .ex_in
    );

    register_file _register_file (
        .clk, .rst_n,
        .rd_a, .rd_b, .data_a, .data_b,
        .wb
    );

    forwarding_controller _forwarding_controller (.ex_in, .wb, .fwd_a, .fwd_b);

    execute_stage _execute_stage (.clk, .rst_n, .ex_in, .fwd_a, .fwd_b, .wb);

    assign wb_valid = wb.valid && wb.load;      // no-ops retire silently.
    assign wb_dest  = wb.dest;
    assign wb_data  = wb.data;

endmodule : cpu

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic                    clk,
    input  logic                    rst_n,

    input  lc3b_types::lc3b_ex_in   ex_in,
    input  lc3b_types::lc3b_fwd_sel fwd_a,
    input  lc3b_types::lc3b_fwd_sel fwd_b,

    output lc3b_types::lc3b_wb_out  wb
);

    import lc3b_types::*;

    lc3b_word opnd_a;
    lc3b_word opnd_b;
    lc3b_word alu_b;
    lc3b_word alu_out;

    // forwarding muxes.
    always_comb begin
        opnd_a = ex_in.sr1_data;
        opnd_b = ex_in.sr2_data;
        if (fwd_a == fwd_wb) begin
            opnd_a = wb.data;
        end
        if (fwd_b == fwd_wb) begin
            opnd_b = wb.data;
        end
    end

    assign alu_b = ex_in.control.use_imm ? ex_in.control.imm : opnd_b;

    always_comb begin
        case (ex_in.control.aluop)
            alu_add: alu_out = opnd_a + alu_b;
            alu_and: alu_out = opnd_a & alu_b;
            alu_not: alu_out = ~opnd_a;
            default: alu_out = opnd_a;
        endcase
    end

    // EX/WB barrier.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
            wb.load  <= 1'b0;
        end else begin
            wb.valid <= ex_in.valid;
            wb.load  <= ex_in.control.load_regfile;
        end
        wb.dest <= ex_in.control.dest;
        wb.data <= alu_out;
    end

endmodule : execute_stage

`default_nettype wire

//--- forwarding_controller.sv
`timescale 1ns/10ps
`default_nettype none

module forwarding_controller (
    input  lc3b_types::lc3b_ex_in   ex_in,
    input  lc3b_types::lc3b_wb_out  wb,

    output lc3b_types::lc3b_fwd_sel fwd_a,
    output lc3b_types::lc3b_fwd_sel fwd_b
);

    import lc3b_types::*;

    logic wb_live;
    logic hit_a;
    logic hit_b;

    // only a valid pair with a register load can forward.
    assign wb_live = ex_in.valid && wb.valid && wb.load;

    assign hit_a = wb_live && (wb.dest == ex_in.control.sr1);

    // immediate forms never read sr2.
    assign hit_b = wb_live && !ex_in.control.use_imm && (wb.dest == ex_in.control.sr2);

    always_comb begin
        fwd_a = fwd_none;
        fwd_b = fwd_none;
        if (hit_a) begin
            fwd_a = fwd_wb;
        end
        if (hit_b) begin
            fwd_b = fwd_wb;
        end
    end

endmodule : forwarding_controller

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,

    input  lc3b_types::lc3b_word  fetch_ir,
    input  logic                  fetch_valid,

    output lc3b_types::lc3b_reg   rd_a,
    output lc3b_types::lc3b_reg   rd_b,
    input  lc3b_types::lc3b_word  data_a,
    input  lc3b_types::lc3b_word  data_b,

    output lc3b_types::lc3b_ex_in ex_in
);

    import lc3b_types::*;

    lc3b_word          if_id_ir;
    logic              if_id_valid;
    lc3b_control_word  control;
    logic signed [4:0] imm5;

    // IF/ID barrier.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_id_valid <= 1'b0;
        end else begin
            if_id_valid <= fetch_valid;     // bubble when no response.
        end
        if (fetch_valid) begin
            if_id_ir <= fetch_ir;
        end
    end

    assign imm5 = if_id_ir[4:0];

    always_comb begin
        control.aluop        = alu_add;
        control.use_imm      = 1'b0;
        control.imm          = lc3b_word'(imm5);
        control.sr1          = if_id_ir[8:6];
        control.sr2          = if_id_ir[2:0];
        control.dest         = if_id_ir[11:9];
        control.load_regfile = 1'b0;
        case (lc3b_opcode'(if_id_ir[15:12]))
            op_add: begin
                control.use_imm      = if_id_ir[5];
                control.load_regfile = 1'b1;
            end
            op_and: begin
                control.aluop        = alu_and;
                control.use_imm      = if_id_ir[5];
                control.load_regfile = 1'b1;
            end
            op_not: begin
                control.aluop        = alu_not;
                control.load_regfile = 1'b1;
            end
            default: control.load_regfile = 1'b0;   // passes down as a no-op.
        endcase
    end

    assign rd_a = control.sr1;
    assign rd_b = control.sr2;

    // ID/EX barrier.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_in.valid <= 1'b0;
        end else begin
            ex_in.valid <= if_id_valid;
        end
        ex_in.control  <= control;
        ex_in.sr1_data <= data_a;
        ex_in.sr2_data <= data_b;
    end

endmodule : decode_stage

`default_nettype wire

//--- register_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_config.svh"

module register_file (
    input  logic                   clk,
    input  logic                   rst_n,

    input  lc3b_types::lc3b_reg    rd_a,
    input  lc3b_types::lc3b_reg    rd_b,
    output lc3b_types::lc3b_word   data_a,
    output lc3b_types::lc3b_word   data_b,

    input  lc3b_types::lc3b_wb_out wb
);

    import lc3b_types::*;

    lc3b_word regs [`LC3B_NUM_REGS];
    logic     wr_en;

    assign wr_en = wb.valid && wb.load;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // write-through bypass lets decode see the value retiring this cycle.
    assign data_a = (wr_en && (wb.dest == rd_a)) ? wb.data : regs[rd_a];
    assign data_b = (wr_en && (wb.dest == rd_b)) ? wb.data : regs[rd_b];

endmodule : register_file

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_config.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 rst_n,

    output logic                 imem_read,
    output lc3b_types::lc3b_word imem_addr,
    input  lc3b_types::lc3b_word imem_rdata,
    input  logic                 imem_resp,

    output lc3b_types::lc3b_word fetch_ir,
    output logic                 fetch_valid
);

    import lc3b_types::*;

    lc3b_fetch_state state;
    lc3b_word        pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= fetch_idle;
            pc    <= `LC3B_RESET_PC;
        end else begin
            case (state)
                fetch_idle: state <= fetch_req;     // open the first request.
                fetch_req: begin
                    // the next request opens at pc + 2 right after a response.
                    if (imem_resp) begin
                        pc <= pc + lc3b_word'(`LC3B_PC_STEP);
                    end
                end
                default: state <= fetch_idle;
            endcase
        end
    end

    assign imem_read = (state == fetch_req);
    assign imem_addr = pc;                          // held until the response.

    // the word goes straight to the IF/ID barrier.
    assign fetch_ir    = imem_rdata;
    assign fetch_valid = imem_resp && (state == fetch_req);

endmodule : fetch_unit

`default_nettype wire

//--- lc3b_types.sv
`default_nettype none

`include "lc3b_config.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [`LC3B_REG_W-1:0] lc3b_reg;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {alu_add, alu_and, alu_not} lc3b_alu_op;

    typedef enum logic {fwd_none, fwd_wb} lc3b_fwd_sel;

    typedef enum logic {fetch_idle, fetch_req} lc3b_fetch_state;

    typedef struct packed {
        lc3b_alu_op aluop;
        logic       use_imm;
        lc3b_word   imm;            // sign-extended imm5.
        lc3b_reg    sr1;
        lc3b_reg    sr2;
        lc3b_reg    dest;
        logic       load_regfile;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_control_word control;
        lc3b_word         sr1_data;
        lc3b_word         sr2_data;
        logic             valid;
    } lc3b_ex_in;

    typedef struct packed {
        lc3b_reg  dest;
        lc3b_word data;
        logic     load;
        logic     valid;
    } lc3b_wb_out;

endpackage : lc3b_types

`default_nettype wire

//--- lc3b_config.svh
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// first fetch address after reset.
`define LC3B_RESET_PC 16'h0000

// data, address and instruction width.
`define LC3B_WORD_W 16

// register index width.
`define LC3B_REG_W 3

// number of general purpose registers.
`define LC3B_NUM_REGS (1 << `LC3B_REG_W)

// byte distance between two instruction words.
`define LC3B_PC_STEP 2

`endif
